//--- build.f
logic/lsi_bus_pkg.sv
logic/lsi_ctrl_pkg.sv
logic/lsi_bus_fsm.sv
logic/lsi_bus_timer.sv
logic/lsi_bus_datapath.sv
logic/lsi_event_ctrl.sv
logic/lsi_bus_top.sv
verification/lsi_bus_assert.sv
verification/lsi_bus_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module lsi_bus_tb -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/lsi_bus_tb.sv
// memory slave decodes adr[8:1] only, never acks at 16'hF000 and up; random ack delay from seed 94
`timescale 1ns/1ps
`default_nettype none

module lsi_bus_tb
   import lsi_bus_pkg::*;
   import lsi_ctrl_pkg::*;
;
   logic             vm_clk_p;
   logic             m_sr;
   logic             cmd_valid_i;
   bus_op_e          cmd_op_i;
   logic [15:0]      cmd_adr_i;
   logic [15:0]      cmd_dat_i;
   logic             vm_aclo_i, vm_evnt_i, vm_halt_i, vm_virq_i;
   logic [1:0]       vm_bsel_i;
   logic [15:0]      wbm_dat_i, wbi_dat_i;
   logic             wbm_ack_i, wbi_ack_i;
   logic             cmd_ready_o, done_o, berr_o, init_o, halt_o;
   logic [15:0]      rdat_o, wbm_adr_o, wbm_dat_o;
   logic [IRQ_W-1:0] irq_o;
   logic             wbm_cyc_o, wbm_stb_o, wbm_we_o, wbi_stb_o;
   logic [1:0]       wbm_sel_o;

   logic [15:0] mem [0:255];           // slave storage
   logic [15:0] ref_mem [0:255];       // expected storage
   logic [15:0] vec_val;               // vector returned on wbi
   logic [1:0]  last_sel;              // sel seen at the last ack
   int          wait_cnt;              // ack delay of current cycle
   int          errors, checks, tests, lat;
   logic [15:0] exp_rdat;
   logic        exp_berr, chk_rdat;
   logic        saw_wbm, saw_wbi;
   logic        ref_aclo, ref_evnt;
   logic [15:0] adrs [0:7];

   lsi_bus_top #(.TIMEOUT_CYCLES(15)) lsi_bus_top_inst (.*);

   always #4 vm_clk_p = ~vm_clk_p;

   // memory slave, classic handshake with 0..3 wait cycles
   always @(posedge vm_clk_p)
   begin
      if (!(wbm_cyc_o && wbm_stb_o) || wbm_ack_i)
      begin
         wbm_ack_i <= 1'b0;
         wait_cnt  <= $urandom % 4;
      end
      else if (wait_cnt > 0)
         wait_cnt <= wait_cnt - 1;
      else if (wbm_adr_o < 16'hF000)                        // upper region stays silent
      begin
         wbm_ack_i <= 1'b1;
         last_sel  <= wbm_sel_o;
         wbm_dat_i <= mem[wbm_adr_o[8:1]];
         if (wbm_we_o && wbm_sel_o[0])
            mem[wbm_adr_o[8:1]][7:0] <= wbm_dat_o[7:0];
         if (wbm_we_o && wbm_sel_o[1])
            mem[wbm_adr_o[8:1]][15:8] <= wbm_dat_o[15:8];
      end
   end

   // vector slave answers in one cycle
   always @(posedge vm_clk_p)
   begin
      wbi_ack_i <= wbi_stb_o & ~wbi_ack_i;
      wbi_dat_i <= vec_val;
   end

   function automatic logic [15:0] ref_merge(input logic [15:0] old, input logic [15:0] dat,
                                             input logic [15:0] adr, input logic is_byte);
      if (!is_byte)
         return dat;
      return adr[0] ? {dat[15:8], old[7:0]} : {old[15:8], dat[7:0]};  // odd adr is high lane
   endfunction

   // expected read result from the model state
   function automatic logic [15:0] ref_rdat(input bus_op_e op, input logic [15:0] adr,
                                            input logic fdin, input logic [3:0] nib);
      if (op == OP_IACK)
         return vec_val;
      if (fdin)
         return {ref_mem[adr[8:1]][15:4], nib};
      return ref_mem[adr[8:1]];
   endfunction

   function automatic logic [IRQ_W-1:0] ref_irq(input logic virq, input logic evnt,
                                                input logic aclo);
      logic [IRQ_W-1:0] r;
      r           = '0;
      r[IRQ_VIRQ] = virq;
      r[IRQ_EVNT] = evnt;
      r[IRQ_ACLO] = aclo;
      return r;
   endfunction

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // response checker, sampled away from the clock edge
   always @(negedge vm_clk_p)
   begin
      if (wbm_stb_o)
         saw_wbm = 1'b1;
      if (wbi_stb_o)
         saw_wbi = 1'b1;
      if (done_o)
      begin
         check_val("berr_o", berr_o, exp_berr);
         if (chk_rdat)
            check_val("rdat_o", rdat_o, exp_rdat);
      end
   end

   // one command; lat counts negedges from accept to done
   task automatic run_cmd(input bus_op_e op, input logic [15:0] adr, input logic [15:0] dat,
                          input logic chk, input logic [15:0] exp, input logic be);
      lat = 0;
      @(posedge vm_clk_p);
      chk_rdat    = chk;                                // held until this done_o
      exp_rdat    = exp;
      exp_berr    = be;
      cmd_valid_i <= 1'b1;
      cmd_op_i    <= op;
      cmd_adr_i   <= adr;
      cmd_dat_i   <= dat;
      @(posedge vm_clk_p);
      cmd_valid_i <= 1'b0;
      do
      begin
         @(negedge vm_clk_p);
         lat++;
         if (lat > 100)
         begin
            $display("timeout: done_o never came for opcode %0d", op);
            $display("CHECKS FAILED");
            $finish;
         end
      end
      while (!done_o);
   endtask

   task automatic flag_cmd(input bus_op_e op);
      run_cmd(op, 16'h0, 16'h0, 1'b0, 16'h0, 1'b0);
      check_val("flag latency", lat, 2);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s finished, errors so far %0d", tests, name, errors);
   endtask

   initial
   begin
      void'($urandom(94));
      vm_clk_p    = 1'b0;
      m_sr        = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_op_i    = OP_READ;
      cmd_adr_i   = '0;
      cmd_dat_i   = '0;
      vm_aclo_i   = 1'b0;
      vm_evnt_i   = 1'b0;
      vm_halt_i   = 1'b0;
      vm_virq_i   = 1'b0;
      vm_bsel_i   = 2'b10;
      wbm_dat_i   = '0;
      wbi_dat_i   = '0;
      wbm_ack_i   = 1'b0;
      wbi_ack_i   = 1'b0;
      vec_val     = 16'o000060;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      saw_wbm     = 1'b0;
      saw_wbi     = 1'b0;
      ref_aclo    = 1'b0;
      ref_evnt    = 1'b0;
      wait_cnt    = 0;
      last_sel    = 2'b00;
      for (int i = 0; i < 256; i++)
      begin
         mem[i]     = {8'(i) ^ 8'hC3, 8'(i)};    // pattern tracks the full index
         ref_mem[i] = {8'(i) ^ 8'hC3, 8'(i)};
      end
      repeat (8) @(posedge vm_clk_p);
      m_sr <= 1'b0;
      @(negedge vm_clk_p);
      check_val("cmd_ready_o after reset", cmd_ready_o, 1);

      check_val("init_o after reset", init_o, 1);
      flag_cmd(OP_CLR_INIT);
      check_val("init_o cleared", init_o, 0);
      flag_cmd(OP_SET_INIT);
      check_val("init_o set", init_o, 1);
      flag_cmd(OP_CLR_INIT);
      end_test("init flag");

      for (int i = 0; i < 8; i++)
      begin
         adrs[i] = {7'b0, 8'($urandom), 1'b0};
         ref_mem[adrs[i][8:1]] = 16'($urandom);
         run_cmd(OP_WRITE, adrs[i], ref_mem[adrs[i][8:1]], 1'b0, 16'h0, 1'b0);
      end
      for (int i = 0; i < 8; i++)
         run_cmd(OP_READ, adrs[i], 16'h0, 1'b1, ref_rdat(OP_READ, adrs[i], 1'b0, 4'h0), 1'b0);
      end_test("word write and read");

      for (int i = 0; i < 2; i++)
      begin
         adrs[i] = (i == 0) ? 16'h0021 : 16'h0040;
         ref_mem[adrs[i][8:1]] = ref_merge(ref_mem[adrs[i][8:1]], 16'hBEEF, adrs[i], 1'b1);
         run_cmd(OP_WRITE_BYTE, adrs[i], 16'hBEEF, 1'b0, 16'h0, 1'b0);
         check_val("wbm_sel_o", last_sel, adrs[i][0] ? 2'b10 : 2'b01);
         run_cmd(OP_READ, adrs[i], 16'h0, 1'b1, ref_rdat(OP_READ, adrs[i], 1'b0, 4'h0), 1'b0);
      end
      end_test("byte write");

      saw_wbm = 1'b0;
      saw_wbi = 1'b0;
      run_cmd(OP_IACK, 16'h0, 16'h0, 1'b1, ref_rdat(OP_IACK, 16'h0, 1'b0, 4'h0), 1'b0);
      check_val("wbi_stb_o seen", saw_wbi, 1);
      check_val("wbm_stb_o seen", saw_wbm, 0);
      end_test("vector fetch");

      run_cmd(OP_READ, 16'hF000, 16'h0, 1'b0, 16'h0, 1'b1);
      flag_cmd(OP_SET_FDIN);
      run_cmd(OP_READ, 16'h0010, 16'h0, 1'b1,
              ref_rdat(OP_READ, 16'h0010, 1'b1, {1'b0, 1'b1, vm_bsel_i}), 1'b0);
      flag_cmd(OP_CLR_BERR);
      flag_cmd(OP_SET_FDIN);
      run_cmd(OP_READ, 16'h0010, 16'h0, 1'b1,
              ref_rdat(OP_READ, 16'h0010, 1'b1, {1'b0, 1'b0, vm_bsel_i}), 1'b0);
      run_cmd(OP_READ, 16'h0010, 16'h0, 1'b1, ref_rdat(OP_READ, 16'h0010, 1'b0, 4'h0), 1'b0);
      end_test("bus timeout and fast input");

      @(posedge vm_clk_p);
      vm_aclo_i <= 1'b1;
      vm_evnt_i <= 1'b1;
      ref_aclo = 1'b1;
      ref_evnt = 1'b1;
      repeat (3) @(negedge vm_clk_p);                  // edge register then latch
      check_val("irq_o after edges", irq_o, ref_irq(1'b0, ref_evnt, ref_aclo));
      check_val("halt_o", halt_o, ref_aclo);
      flag_cmd(OP_CLR_ACLO);
      ref_aclo = 1'b0;
      check_val("irq_o after CLR_ACLO", irq_o, ref_irq(1'b0, ref_evnt, ref_aclo));
      check_val("halt_o cleared", halt_o, ref_aclo);
      flag_cmd(OP_CLR_EVNT);
      ref_evnt = 1'b0;
      check_val("irq_o after CLR_EVNT", irq_o, ref_irq(1'b0, ref_evnt, ref_aclo));
      @(posedge vm_clk_p);
      vm_virq_i <= 1'b1;
      vm_aclo_i <= 1'b0;
      vm_evnt_i <= 1'b0;
      @(negedge vm_clk_p);
      check_val("irq_o virq", irq_o, ref_irq(1'b1, ref_evnt, ref_aclo));
      end_test("interrupt requests");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/lsi_bus_assert.sv
// bound into lsi_bus_top; wbm handshake and done_o checks, off while m_sr is high
`timescale 1ns/1ps
`default_nettype none

module lsi_bus_assert
(
   input wire        vm_clk_p,
   input wire        m_sr,
   input wire        wbm_cyc_o,
   input wire        wbm_stb_o,
   input wire        wbm_ack_i,
   input wire        wbm_we_o,
   input wire [15:0] wbm_adr_o,
   input wire [15:0] wbm_dat_o,
   input wire [1:0]  wbm_sel_o,
   input wire        done_o
);

   stb_needs_cyc: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      wbm_stb_o |-> wbm_cyc_o)
      else $error("stb without cyc");

   // master holds its outputs until the slave answers or the timer aborts
   hold_while_wait: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      (wbm_stb_o && !wbm_ack_i) |=> (!wbm_stb_o || ($stable(wbm_adr_o) && $stable(wbm_dat_o)
                                     && $stable(wbm_we_o) && $stable(wbm_sel_o))))
      else $error("wbm outputs moved before ack");

   done_single: assert property (@(posedge vm_clk_p) disable iff (m_sr)
      done_o |=> !done_o)
      else $error("done_o longer than one cycle");

endmodule

bind lsi_bus_top lsi_bus_assert lsi_bus_assert_inst (
   .vm_clk_p  (vm_clk_p),
   .m_sr      (m_sr),
   .wbm_cyc_o (wbm_cyc_o),
   .wbm_stb_o (wbm_stb_o),
   .wbm_ack_i (wbm_ack_i),
   .wbm_we_o  (wbm_we_o),
   .wbm_adr_o (wbm_adr_o),
   .wbm_dat_o (wbm_dat_o),
   .wbm_sel_o (wbm_sel_o),
   .done_o    (done_o)
);

`default_nettype wire

//--- logic/lsi_bus_top.sv
// single clock vm_clk_p; no bus grant, no slow clock mode; one command in flight until done_o
`timescale 1ns/1ps
`default_nettype none

module lsi_bus_top
   import lsi_bus_pkg::*;
   import lsi_ctrl_pkg::*;
#(
   parameter int TIMEOUT_CYCLES = 63
)
(
   input  logic             vm_clk_p,
   input  logic             m_sr,
   input  logic             cmd_valid_i,
   input  bus_op_e          cmd_op_i,
   input  logic [ADR_W-1:0] cmd_adr_i,
   input  logic [DAT_W-1:0] cmd_dat_i,
   input  logic             vm_aclo_i,
   input  logic             vm_evnt_i,
   input  logic             vm_halt_i,
   input  logic             vm_virq_i,
   input  logic [1:0]       vm_bsel_i,
   input  logic [DAT_W-1:0] wbm_dat_i,
   input  logic             wbm_ack_i,
   input  logic [DAT_W-1:0] wbi_dat_i,
   input  logic             wbi_ack_i,
   output logic             cmd_ready_o,
   output logic             done_o,
   output logic             berr_o,
   output logic [DAT_W-1:0] rdat_o,
   output logic             init_o,
   output logic [IRQ_W-1:0] irq_o,
   output logic             halt_o,
   output logic [ADR_W-1:0] wbm_adr_o,
   output logic [DAT_W-1:0] wbm_dat_o,
   output logic             wbm_cyc_o,
   output logic             wbm_stb_o,
   output logic             wbm_we_o,
   output logic [1:0]       wbm_sel_o,
   output logic             wbi_stb_o
);

   logic       adr_load;
   logic       dat_load;
   logic       rd_capture;
   logic       byte_wr;
   logic       stb_active;
   logic       exec;
   logic       cyc_end;
   logic       timeout;
   logic       fdin_en;
   logic [3:0] fdin;

   lsi_bus_fsm lsi_bus_fsm_inst (
      .vm_clk_p     (vm_clk_p),
      .m_sr         (m_sr),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_op_i     (cmd_op_i),
      .wbm_ack_i    (wbm_ack_i),
      .wbi_ack_i    (wbi_ack_i),
      .timeout_i    (timeout),
      .cmd_ready_o  (cmd_ready_o),
      .adr_load_o   (adr_load),
      .dat_load_o   (dat_load),
      .rd_capture_o (rd_capture),
      .wbm_cyc_o    (wbm_cyc_o),
      .wbm_stb_o    (wbm_stb_o),
      .wbm_we_o     (wbm_we_o),
      .byte_o       (byte_wr),
      .wbi_stb_o    (wbi_stb_o),
      .stb_active_o (stb_active),
      .exec_o       (exec),
      .cyc_end_o    (cyc_end),
      .done_o       (done_o),
      .berr_o       (berr_o)
   );

   lsi_bus_timer #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) lsi_bus_timer_inst (
      .vm_clk_p     (vm_clk_p),
      .m_sr         (m_sr),
      .stb_active_i (stb_active),
      .timeout_o    (timeout)
   );

   lsi_bus_datapath lsi_bus_datapath_inst (
      .vm_clk_p     (vm_clk_p),
      .m_sr         (m_sr),
      .adr_load_i   (adr_load),
      .dat_load_i   (dat_load),
      .byte_i       (byte_wr),
      .rd_capture_i (rd_capture),
      .vec_sel_i    (wbi_stb_o),           // vector strobe marks a wbi read
      .cmd_adr_i    (cmd_adr_i),
      .cmd_dat_i    (cmd_dat_i),
      .wbm_dat_i    (wbm_dat_i),
      .wbi_dat_i    (wbi_dat_i),
      .fdin_en_i    (fdin_en),
      .fdin_i       (fdin),
      .wbm_adr_o    (wbm_adr_o),
      .wbm_dat_o    (wbm_dat_o),
      .wbm_sel_o    (wbm_sel_o),
      .rdat_o       (rdat_o)
   );

   lsi_event_ctrl lsi_event_ctrl_inst (
      .vm_clk_p  (vm_clk_p),
      .m_sr      (m_sr),
      .exec_i    (exec),
      .op_i      (cmd_op_i),
      .timeout_i (timeout),
      .cyc_end_i (cyc_end),
      .vm_aclo_i (vm_aclo_i),
      .vm_evnt_i (vm_evnt_i),
      .vm_halt_i (vm_halt_i),
      .vm_virq_i (vm_virq_i),
      .vm_bsel_i (vm_bsel_i),
      .init_o    (init_o),
      .irq_o     (irq_o),
      .halt_o    (halt_o),
      .fdin_en_o (fdin_en),
      .fdin_o    (fdin)
   );

endmodule

`default_nettype wire

//--- logic/lsi_event_ctrl.sv
// inputs assumed synchronous to vm_clk_p; edges reach irq_o two cycles later; INIT is high out of reset
`timescale 1ns/1ps
`default_nettype none

module lsi_event_ctrl
   import lsi_bus_pkg::*;
   import lsi_ctrl_pkg::*;
(
   input  logic             vm_clk_p,
   input  logic             m_sr,
   input  logic             exec_i,           // command accepted
   input  bus_op_e          op_i,
   input  logic             timeout_i,
   input  logic             cyc_end_i,
   input  logic             vm_aclo_i,
   input  logic             vm_evnt_i,
   input  logic             vm_halt_i,
   input  logic             vm_virq_i,
   input  logic [1:0]       vm_bsel_i,
   output logic             init_o,
   output logic [IRQ_W-1:0] irq_o,
   output logic             halt_o,
   output logic             fdin_en_o,
   output logic [3:0]       fdin_o
);

   bus_op_e op_q;                      // opcode held past accept
   logic    run_q;                     // flag command executes now
   logic    aclo_d;                    // previous input levels
   logic    evnt_d;
   logic    aclo_ed;                   // one-cycle edge registers
   logic    evnt_ed;
   logic    aclo_rq;
   logic    evnt_rq;
   logic    berr_st;                   // sticky until cleared or INIT

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
      begin
         run_q     <= 1'b0;
         aclo_d    <= 1'b0;
         evnt_d    <= 1'b0;
         aclo_ed   <= 1'b0;
         evnt_ed   <= 1'b0;
         aclo_rq   <= 1'b0;
         evnt_rq   <= 1'b0;
         init_o    <= 1'b1;                        // peripherals held in reset
         berr_st   <= 1'b0;
         fdin_en_o <= 1'b0;
      end
      else
      begin
         run_q   <= exec_i;
         aclo_d  <= vm_aclo_i;
         evnt_d  <= vm_evnt_i;
         aclo_ed <= vm_aclo_i & ~aclo_d;           // rising edges only
         evnt_ed <= vm_evnt_i & ~evnt_d;

         if (run_q && op_q == OP_CLR_ACLO)
            aclo_rq <= 1'b0;
         else if (aclo_ed)
            aclo_rq <= 1'b1;

         if (run_q && op_q == OP_CLR_EVNT)
            evnt_rq <= 1'b0;
         else if (evnt_ed)
            evnt_rq <= 1'b1;

         if (run_q && op_q == OP_SET_INIT)
            init_o <= 1'b1;
         else if (run_q && op_q == OP_CLR_INIT)
            init_o <= 1'b0;

         if (init_o || (run_q && op_q == OP_CLR_BERR))
            berr_st <= 1'b0;
         else if (timeout_i)
            berr_st <= 1'b1;

         if (cyc_end_i)
            fdin_en_o <= 1'b0;                     // good for one wbm cycle
         else if (run_q && op_q == OP_SET_FDIN)
            fdin_en_o <= 1'b1;
      end
   end

   always_ff @(posedge vm_clk_p)
   begin
      if (exec_i)
         op_q <= op_i;
   end

   assign irq_o[IRQ_VIRQ] = vm_virq_i;             // no latch, device holds it
   assign irq_o[IRQ_EVNT] = evnt_rq;
   assign irq_o[IRQ_ACLO] = aclo_rq;
   assign halt_o          = vm_halt_i | aclo_rq;

   assign fdin_o[FDIN_BSEL0] = vm_bsel_i[0];
   assign fdin_o[FDIN_BSEL1] = vm_bsel_i[1];
   assign fdin_o[FDIN_BERR]  = berr_st;
   assign fdin_o[FDIN_ACLO]  = vm_aclo_i | aclo_rq;

endmodule

`default_nettype wire

//--- logic/lsi_bus_datapath.sv
// address and write data load on accept; read data captured on ack; fast input only merges wbm reads
`timescale 1ns/1ps
`default_nettype none

module lsi_bus_datapath
   import lsi_bus_pkg::*;
   import lsi_ctrl_pkg::*;
(
   input  logic             vm_clk_p,
   input  logic             m_sr,
   input  logic             adr_load_i,
   input  logic             dat_load_i,
   input  logic             byte_i,
   input  logic             rd_capture_i,
   input  logic             vec_sel_i,        // capture from wbi
   input  logic [ADR_W-1:0] cmd_adr_i,
   input  logic [DAT_W-1:0] cmd_dat_i,
   input  logic [DAT_W-1:0] wbm_dat_i,
   input  logic [DAT_W-1:0] wbi_dat_i,
   input  logic             fdin_en_i,
   input  logic [3:0]       fdin_i,
   output logic [ADR_W-1:0] wbm_adr_o,
   output logic [DAT_W-1:0] wbm_dat_o,
   output logic [1:0]       wbm_sel_o,
   output logic [DAT_W-1:0] rdat_o
);

   logic [DAT_W-1:0] rd_mux;           // selected read source

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         wbm_sel_o <= 2'b11;
      else if (adr_load_i)
         wbm_sel_o <= byte_i ? (cmd_adr_i[0] ? 2'b10 : 2'b01) : 2'b11;  // odd adr is high lane
   end

   always_ff @(posedge vm_clk_p)
   begin
      if (adr_load_i)
         wbm_adr_o <= cmd_adr_i;
      if (dat_load_i)
         wbm_dat_o <= cmd_dat_i;
      if (rd_capture_i)
         rdat_o <= rd_mux;
   end

   always_comb
   begin
      if (vec_sel_i)
         rd_mux = wbi_dat_i;                                  // vector passes as is
      else if (fdin_en_i)
         rd_mux = {wbm_dat_i[DAT_W-1:FDIN_ACLO+1], fdin_i};   // status over low nibble
      else
         rd_mux = wbm_dat_i;
   end

endmodule

`default_nettype wire

//--- logic/lsi_bus_timer.sv
// reply timer; timeout pulses once after TIMEOUT_CYCLES strobe cycles, holds quiet until strobe drops
`timescale 1ns/1ps
`default_nettype none

module lsi_bus_timer
#(
   parameter int TIMEOUT_CYCLES = 63
)
(
   input  logic vm_clk_p,
   input  logic m_sr,
   input  logic stb_active_i,          // wbm or wbi strobe high
   output logic timeout_o              // bus error request
);

   localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

   logic [CNT_W-1:0] cnt_q;            // strobe cycles seen so far

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
         cnt_q <= '0;
      else if (!stb_active_i)
         cnt_q <= '0;                              // restart per transaction
      else if (cnt_q != CNT_W'(TIMEOUT_CYCLES))
         cnt_q <= cnt_q + 1'b1;                    // saturate, no wrap
   end

   // last strobe cycle of the allowed window
   assign timeout_o = stb_active_i & (cnt_q == CNT_W'(TIMEOUT_CYCLES - 1));

endmodule

`default_nettype wire

//--- logic/lsi_bus_fsm.sv
// one command at a time; caller waits for done_o; no pipelining on wbm, wbi uses stb only
`timescale 1ns/1ps
`default_nettype none

module lsi_bus_fsm
   import lsi_bus_pkg::*;
(
   input  logic    vm_clk_p,
   input  logic    m_sr,
   input  logic    cmd_valid_i,
   input  bus_op_e cmd_op_i,
   input  logic    wbm_ack_i,
   input  logic    wbi_ack_i,
   input  logic    timeout_i,
   output logic    cmd_ready_o,
   output logic    adr_load_o,         // latch address and sel
   output logic    dat_load_o,         // latch write data
   output logic    rd_capture_o,       // capture read or vector data
   output logic    wbm_cyc_o,
   output logic    wbm_stb_o,
   output logic    wbm_we_o,
   output logic    byte_o,             // byte write decode
   output logic    wbi_stb_o,
   output logic    stb_active_o,       // runs the reply timer
   output logic    exec_o,             // command accepted
   output logic    cyc_end_o,          // wbm cycle finishes
   output logic    done_o,
   output logic    berr_o
);

   bus_state_e state;
   bus_state_e state_nx;
   logic       accept;
   logic       is_wr;
   logic       is_mem;
   logic       mem_end;
   logic       vec_end;
   logic       abort_q;                // cycle ended by timeout

   assign cmd_ready_o = (state == ST_IDLE);
   assign accept      = cmd_valid_i & cmd_ready_o;
   assign is_wr       = (cmd_op_i == OP_WRITE) | (cmd_op_i == OP_WRITE_BYTE);
   assign is_mem      = is_wr | (cmd_op_i == OP_READ);
   assign mem_end     = (state == ST_MEM) & (wbm_ack_i | timeout_i);
   assign vec_end     = (state == ST_VEC) & (wbi_ack_i | timeout_i);

   always_comb
   begin
      state_nx = state;
      case (state)
         ST_IDLE:
            if (accept)
               state_nx = is_mem ? ST_MEM : ((cmd_op_i == OP_IACK) ? ST_VEC : ST_FLAG);
         ST_MEM:
            if (mem_end)
               state_nx = ST_DONE;
         ST_VEC:
            if (vec_end)
               state_nx = ST_DONE;
         ST_FLAG: state_nx = ST_DONE;    // flag updates during this cycle
         default: state_nx = ST_IDLE;    // ST_DONE and unused codes
      endcase
   end

   always_ff @(posedge vm_clk_p or posedge m_sr)
   begin
      if (m_sr)
      begin
         state     <= ST_IDLE;
         wbm_cyc_o <= 1'b0;
         wbm_stb_o <= 1'b0;
         wbm_we_o  <= 1'b0;
         wbi_stb_o <= 1'b0;
         abort_q   <= 1'b0;
      end
      else
      begin
         state <= state_nx;
         if (accept)
         begin
            wbm_cyc_o <= is_mem;                     // cyc and stb rise together
            wbm_stb_o <= is_mem;
            wbm_we_o  <= is_wr;
            wbi_stb_o <= (cmd_op_i == OP_IACK);
            abort_q   <= 1'b0;
         end
         else
         begin
            if (mem_end)
            begin
               wbm_cyc_o <= 1'b0;                   // drop after ack sampled
               wbm_stb_o <= 1'b0;
               wbm_we_o  <= 1'b0;
               abort_q   <= ~wbm_ack_i;             // late ack still wins
            end
            if (vec_end)
            begin
               wbi_stb_o <= 1'b0;
               abort_q   <= ~wbi_ack_i;
            end
         end
      end
   end

   assign adr_load_o   = accept;
   assign dat_load_o   = accept & is_wr;
   assign byte_o       = (cmd_op_i == OP_WRITE_BYTE);
   assign rd_capture_o = ((state == ST_MEM) & wbm_ack_i & ~wbm_we_o)
                       | ((state == ST_VEC) & wbi_ack_i);
   assign stb_active_o = wbm_stb_o | wbi_stb_o;
   assign exec_o       = accept;
   assign cyc_end_o    = mem_end;
   assign done_o       = (state == ST_DONE);
   assign berr_o       = done_o & abort_q;              // only meaningful with done

endmodule

`default_nettype wire

//--- logic/lsi_ctrl_pkg.sv
// bit positions must agree with how software reads irq_o and the fast input nibble
`default_nettype none

package lsi_ctrl_pkg;

   // interrupt request vector
   localparam int IRQ_VIRQ = 0;        // vectored request, passed through
   localparam int IRQ_EVNT = 1;        // latched timer event
   localparam int IRQ_ACLO = 2;        // latched power fail
   localparam int IRQ_W    = 3;

   // fast data input nibble, replaces read data bits 3..0
   localparam int FDIN_BSEL0 = 0;      // boot selector low
   localparam int FDIN_BSEL1 = 1;      // boot selector high
   localparam int FDIN_BERR  = 2;      // sticky bus error
   localparam int FDIN_ACLO  = 3;      // power fail, live or latched

endpackage

`default_nettype wire

//--- logic/lsi_bus_pkg.sv
// bus widths fixed at 16 bits; opcode values only matter for trace readability, hardware decodes by name
`default_nettype none

package lsi_bus_pkg;

   localparam int ADR_W = 16;          // Q-bus style word address
   localparam int DAT_W = 16;          // word data

   // commands issued in place of the microcode control chip
   typedef enum logic [3:0] {
      OP_READ       = 4'h0,            // word read on wbm
      OP_WRITE      = 4'h1,            // word write on wbm
      OP_WRITE_BYTE = 4'h2,            // byte write, lane from adr[0]
      OP_IACK       = 4'h3,            // vector fetch on wbi
      OP_SET_INIT   = 4'h4,            // assert peripheral INIT
      OP_CLR_INIT   = 4'h5,            // release peripheral INIT
      OP_CLR_BERR   = 4'h6,            // clear sticky bus error
      OP_CLR_ACLO   = 4'h7,            // drop power fail request
      OP_CLR_EVNT   = 4'h8,            // drop timer event request
      OP_SET_FDIN   = 4'h9             // next read gets status nibble
   } bus_op_e;

   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,                  // ready for a command
      ST_MEM  = 3'd1,                  // wbm handshake running
      ST_VEC  = 3'd2,                  // wbi vector strobe running
      ST_FLAG = 3'd3,                  // flag command executes
      ST_DONE = 3'd4                   // completion pulse
   } bus_state_e;

endpackage

`default_nettype wire
